// File: hw/na_config.svh
`ifndef NA_CONFIG_SVH
`define NA_CONFIG_SVH

// Flit and bus data width
`define NA_FLIT_W 32

// Header field widths
`define NA_ID_W 5
`define NA_CLASS_W 3

// Remaining header bits, unused on the wire
`define NA_RSVD_W (`NA_FLIT_W - 2 * `NA_ID_W - `NA_CLASS_W)

// FIFO depths in words
`define NA_TX_DEPTH 8
`define NA_RX_DEPTH 8

// Message length, covers 0 to 8 words
`define NA_LEN_W 4

// Register bus address width
`define NA_ADDR_W 2

// Register map
`define NA_REG_DATA 0
`define NA_REG_SEND 1
`define NA_REG_STATUS 2

// Class carried by every outgoing packet
`define NA_CLASS_MP 0

`endif

// File: hw/na_pkg.sv
`default_nettype none

`include "na_config.svh"

package na_pkg;

   // Header view of a flit, dest in the top bits
   typedef struct packed {
      logic [`NA_ID_W-1:0]    dest;
      logic [`NA_CLASS_W-1:0] msg_class;
      logic [`NA_ID_W-1:0]    src;
      logic [`NA_RSVD_W-1:0]  rsvd;
   } noc_hdr_t;

   // First flit reads as header, the rest as payload
   typedef union packed {
      noc_hdr_t              hdr;
      logic [`NA_FLIT_W-1:0] data;
   } noc_flit_u;

   // Forward half of a link, ready runs separately
   typedef struct packed {
      noc_flit_u flit;
      logic      last;
      logic      valid;
   } noc_link_t;

   // Register bus request
   typedef struct packed {
      logic                  valid;
      logic                  we;
      logic [`NA_ADDR_W-1:0] addr;
      logic [`NA_FLIT_W-1:0] wdata;
   } na_bus_req_t;

   // Send command for the packetizer
   typedef struct packed {
      logic [`NA_ID_W-1:0]  dest;
      logic [`NA_LEN_W-1:0] len;
   } na_send_t;

   // One receive FIFO word with its end-of-message flag
   typedef struct packed {
      logic [`NA_FLIT_W-1:0] data;
      logic                  last;
   } rx_entry_t;

endpackage

`default_nettype wire

// File: hw/msg_fifo.sv
`default_nettype none

module msg_fifo #(
   parameter int unsigned WIDTH = 32,
   parameter int unsigned DEPTH = 8
) (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         push_i,
   input  logic [WIDTH-1:0]             push_data_i,
   input  logic                         pop_i,
   output logic [WIDTH-1:0]             pop_data_o,
   output logic                         full_o,
   output logic                         empty_o,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   // Storage, no reset needed
   logic [WIDTH-1:0] mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             do_push;
   logic             do_pop;

   // Full and empty derived from the word count
   assign full_o  = (cnt_q == CNT_W'(DEPTH));
   assign empty_o = (cnt_q == '0);
   assign count_o = cnt_q;

   // Requests beyond capacity are ignored
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   // Head entry always visible
   assign pop_data_o = mem_q[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         // Pointers wrap at DEPTH, not at a power of two
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Push and pop together leave the count alone
         if (do_push && !do_pop) begin
            cnt_q <= cnt_q + 1'b1;
         end else if (do_pop && !do_push) begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/noc_packetizer.sv
`default_nettype none

`include "na_config.svh"

module noc_packetizer #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic                  clk,
   input  logic                  rst_i,
   input  na_pkg::na_send_t      send_i,
   input  logic                  send_valid_i,
   output logic                  send_ready_o,
   input  logic [`NA_FLIT_W-1:0] tx_data_i,
   input  logic                  tx_empty_i,
   output logic                  tx_pop_o,
   output na_pkg::noc_link_t     noc_out_o,
   input  logic                  noc_out_ready_i
);

   import na_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HDR,
      ST_PAYLOAD
   } pkt_state_e;

   // Source id as it appears in the header
   localparam logic [`NA_ID_W-1:0]  SRC_ID  = TILE_ID[`NA_ID_W-1:0];
   localparam logic [`NA_LEN_W-1:0] LEN_ONE = 1;

   pkt_state_e           state_q;
   logic [`NA_ID_W-1:0]  dest_q;
   // Payload flits still to send
   logic [`NA_LEN_W-1:0] rem_q;
   noc_hdr_t             hdr;
   logic                 out_fire;

   // New command only taken when idle
   assign send_ready_o = (state_q == ST_IDLE);
   assign out_fire     = noc_out_o.valid && noc_out_ready_i;
   // One word leaves the tx FIFO per accepted payload flit
   assign tx_pop_o     = out_fire && (state_q == ST_PAYLOAD);

   // Header fields
   always_comb begin
      hdr           = '0;
      hdr.dest      = dest_q;
      hdr.msg_class = `NA_CLASS_MP;
      hdr.src       = SRC_ID;
   end

   // Output flit straight from state and FIFO head, so it holds while stalled
   always_comb begin
      noc_out_o = '0;
      case (state_q)
         ST_HDR: begin
            noc_out_o.valid    = 1'b1;
            noc_out_o.flit.hdr = hdr;
            // Zero-length message ends with its header
            noc_out_o.last     = (rem_q == '0);
         end
         ST_PAYLOAD: begin
            noc_out_o.valid     = !tx_empty_i;
            noc_out_o.flit.data = tx_data_i;
            noc_out_o.last      = (rem_q == LEN_ONE);
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         dest_q  <= '0;
         rem_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               // Latch command, header goes out next cycle
               if (send_valid_i) begin
                  dest_q  <= send_i.dest;
                  rem_q   <= send_i.len;
                  state_q <= ST_HDR;
               end
            end
            ST_HDR: begin
               if (out_fire) begin
                  state_q <= (rem_q == '0) ? ST_IDLE : ST_PAYLOAD;
               end
            end
            ST_PAYLOAD: begin
               if (out_fire) begin
                  rem_q <= rem_q - 1'b1;
                  if (rem_q == LEN_ONE) begin
                     state_q <= ST_IDLE;
                  end
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/noc_depacketizer.sv
`default_nettype none

`include "na_config.svh"

module noc_depacketizer #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic              clk,
   input  logic              rst_i,
   input  na_pkg::noc_link_t noc_in_i,
   output logic              noc_in_ready_o,
   output logic              rx_push_o,
   output na_pkg::rx_entry_t rx_entry_o,
   input  logic              rx_full_i,
   output logic              drop_o
);

   import na_pkg::*;

   typedef enum logic [1:0] {
      ST_HEAD,
      ST_PAYLOAD,
      ST_DRAIN
   } depkt_state_e;

   localparam logic [`NA_ID_W-1:0] MY_ID = TILE_ID[`NA_ID_W-1:0];

   depkt_state_e state_q;
   noc_hdr_t     in_hdr;
   logic         in_fire;
   logic         hdr_fire;
   logic         hdr_match;
   logic         drop_q;

   // First flit of a packet decoded as header
   assign in_hdr    = noc_in_i.flit.hdr;
   assign hdr_match = (in_hdr.dest == MY_ID);

   // Only local payload can be held back, by a full rx FIFO
   assign noc_in_ready_o = (state_q == ST_PAYLOAD) ? !rx_full_i : 1'b1;
   assign in_fire        = noc_in_i.valid && noc_in_ready_o;
   assign hdr_fire       = in_fire && (state_q == ST_HEAD);

   // Payload word goes to rx FIFO with its last bit
   assign rx_push_o       = in_fire && (state_q == ST_PAYLOAD);
   assign rx_entry_o.data = noc_in_i.flit.data;
   assign rx_entry_o.last = noc_in_i.last;

   assign drop_o = drop_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= ST_HEAD;
         drop_q  <= 1'b0;
      end else begin
         // Single pulse per misrouted header
         drop_q <= hdr_fire && !hdr_match;
         case (state_q)
            ST_HEAD: begin
               // Single-flit packets stay in ST_HEAD
               if (hdr_fire && !noc_in_i.last) begin
                  state_q <= hdr_match ? ST_PAYLOAD : ST_DRAIN;
               end
            end
            ST_PAYLOAD: begin
               if (in_fire && noc_in_i.last) begin
                  state_q <= ST_HEAD;
               end
            end
            ST_DRAIN: begin
               // Swallow flits of the foreign packet
               if (in_fire && noc_in_i.last) begin
                  state_q <= ST_HEAD;
               end
            end
            default: state_q <= ST_HEAD;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/na_ctrl.sv
`default_nettype none

`include "na_config.svh"

module na_ctrl (
   input  logic                  clk,
   input  logic                  rst_i,
   input  na_pkg::na_bus_req_t   bus_req_i,
   output logic                  bus_ready_o,
   output logic [`NA_FLIT_W-1:0] bus_rdata_o,
   output logic                  bus_rvalid_o,
   output logic                  tx_push_o,
   output logic [`NA_FLIT_W-1:0] tx_data_o,
   input  logic                  tx_full_i,
   output na_pkg::na_send_t      send_o,
   output logic                  send_valid_o,
   input  logic                  send_ready_i,
   output logic                  rx_pop_o,
   input  na_pkg::rx_entry_t     rx_entry_i,
   input  logic                  rx_empty_i,
   input  logic                  drop_i
);

   localparam logic [`NA_ADDR_W-1:0] REG_DATA   = `NA_REG_DATA;
   localparam logic [`NA_ADDR_W-1:0] REG_SEND   = `NA_REG_SEND;
   localparam logic [`NA_ADDR_W-1:0] REG_STATUS = `NA_REG_STATUS;

   logic                  wr_data;
   logic                  wr_send;
   logic                  rd_req;
   logic                  bus_fire;
   // Words written since the last accepted SEND
   logic [`NA_LEN_W-1:0]  pending_q;
   logic [7:0]            drop_cnt_q;
   logic [`NA_FLIT_W-1:0] status_w;
   logic [`NA_FLIT_W-1:0] rdata_d;
   logic [`NA_FLIT_W-1:0] rdata_q;
   logic                  rvalid_q;

   // Address decode
   assign wr_data = bus_req_i.we && (bus_req_i.addr == REG_DATA);
   assign wr_send = bus_req_i.we && (bus_req_i.addr == REG_SEND);
   assign rd_req  = !bus_req_i.we;

   // Stall DATA writes on full tx FIFO, SEND while packetizer busy
   assign bus_ready_o = !(wr_data && tx_full_i) && !(wr_send && !send_ready_i);
   assign bus_fire    = bus_req_i.valid && bus_ready_o;

   assign tx_push_o = bus_fire && wr_data;
   assign tx_data_o = bus_req_i.wdata;

   // Command handshake coincides with bus completion
   assign send_valid_o = bus_req_i.valid && wr_send;
   assign send_o.dest  = bus_req_i.wdata[`NA_ID_W-1:0];
   assign send_o.len   = pending_q;

   // Pop only when there is something to return
   assign rx_pop_o = bus_fire && rd_req && (bus_req_i.addr == REG_DATA) && !rx_empty_i;

   // Status word
   always_comb begin
      status_w        = '0;
      status_w[0]     = !rx_empty_i;
      status_w[1]     = !rx_empty_i && rx_entry_i.last;
      status_w[15:8]  = 8'(pending_q);
      status_w[23:16] = drop_cnt_q;
   end

   // Read mux, unmapped addresses and empty DATA give 0
   always_comb begin
      rdata_d = '0;
      if (bus_req_i.addr == REG_DATA && !rx_empty_i) begin
         rdata_d = rx_entry_i.data;
      end else if (bus_req_i.addr == REG_STATUS) begin
         rdata_d = status_w;
      end
   end

   // Read data one cycle after the request
   always_ff @(posedge clk) begin
      rdata_q <= rdata_d;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         rvalid_q   <= 1'b0;
         pending_q  <= '0;
         drop_cnt_q <= '0;
      end else begin
         rvalid_q <= bus_fire && rd_req;
         if (tx_push_o) begin
            pending_q <= pending_q + 1'b1;
         end else if (bus_fire && wr_send) begin
            pending_q <= '0;
         end
         // Wraps at 256
         if (drop_i) begin
            drop_cnt_q <= drop_cnt_q + 1'b1;
         end
      end
   end

   assign bus_rdata_o  = rdata_q;
   assign bus_rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: hw/na_mpsimple_top.sv
`default_nettype none

`include "na_config.svh"

module na_mpsimple_top #(
   parameter int unsigned TILE_ID = 3
) (
   input  logic                  clk,
   input  logic                  rst_i,
   input  na_pkg::na_bus_req_t   bus_req_i,
   output logic                  bus_ready_o,
   output logic [`NA_FLIT_W-1:0] bus_rdata_o,
   output logic                  bus_rvalid_o,
   input  na_pkg::noc_link_t     noc_in_i,
   output logic                  noc_in_ready_o,
   output na_pkg::noc_link_t     noc_out_o,
   input  logic                  noc_out_ready_i
);

   import na_pkg::*;

   // Transmit side
   logic                  tx_push;
   logic [`NA_FLIT_W-1:0] tx_wdata;
   logic                  tx_pop;
   logic [`NA_FLIT_W-1:0] tx_head;
   logic                  tx_full;
   logic                  tx_empty;
   na_send_t              send;
   logic                  send_valid;
   logic                  send_ready;

   // Receive side
   logic                  rx_push;
   rx_entry_t             rx_wentry;
   logic                  rx_pop;
   rx_entry_t             rx_head;
   logic                  rx_full;
   logic                  rx_empty;
   logic                  drop;

   na_ctrl u_ctrl (
      .clk          (clk),
      .rst_i        (rst_i),
      .bus_req_i    (bus_req_i),
      .bus_ready_o  (bus_ready_o),
      .bus_rdata_o  (bus_rdata_o),
      .bus_rvalid_o (bus_rvalid_o),
      .tx_push_o    (tx_push),
      .tx_data_o    (tx_wdata),
      .tx_full_i    (tx_full),
      .send_o       (send),
      .send_valid_o (send_valid),
      .send_ready_i (send_ready),
      .rx_pop_o     (rx_pop),
      .rx_entry_i   (rx_head),
      .rx_empty_i   (rx_empty),
      .drop_i       (drop)
   );

   // Payload words waiting for a SEND
   msg_fifo #(
      .WIDTH (`NA_FLIT_W),
      .DEPTH (`NA_TX_DEPTH)
   ) u_tx_fifo (
      .clk         (clk),
      .rst_i       (rst_i),
      .push_i      (tx_push),
      .push_data_i (tx_wdata),
      .pop_i       (tx_pop),
      .pop_data_o  (tx_head),
      .full_o      (tx_full),
      .empty_o     (tx_empty),
      .count_o     ()
   );

   // Received words plus end-of-message flag
   msg_fifo #(
      .WIDTH ($bits(rx_entry_t)),
      .DEPTH (`NA_RX_DEPTH)
   ) u_rx_fifo (
      .clk         (clk),
      .rst_i       (rst_i),
      .push_i      (rx_push),
      .push_data_i (rx_wentry),
      .pop_i       (rx_pop),
      .pop_data_o  (rx_head),
      .full_o      (rx_full),
      .empty_o     (rx_empty),
      .count_o     ()
   );

   noc_packetizer #(
      .TILE_ID (TILE_ID)
   ) u_packetizer (
      .clk             (clk),
      .rst_i           (rst_i),
      .send_i          (send),
      .send_valid_i    (send_valid),
      .send_ready_o    (send_ready),
      .tx_data_i       (tx_head),
      .tx_empty_i      (tx_empty),
      .tx_pop_o        (tx_pop),
      .noc_out_o       (noc_out_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

   noc_depacketizer #(
      .TILE_ID (TILE_ID)
   ) u_depacketizer (
      .clk            (clk),
      .rst_i          (rst_i),
      .noc_in_i       (noc_in_i),
      .noc_in_ready_o (noc_in_ready_o),
      .rx_push_o      (rx_push),
      .rx_entry_o     (rx_wentry),
      .rx_full_i      (rx_full),
      .drop_o         (drop)
   );

endmodule

`default_nettype wire

// File: verif/na_mpsimple_sva.sv
`default_nettype none

`include "na_config.svh"

module na_mpsimple_sva (
   input logic                clk,
   input logic                rst_i,
   input na_pkg::na_bus_req_t bus_req_i,
   input logic                bus_ready_i,
   input na_pkg::noc_link_t   noc_out_i,
   input logic                noc_out_ready_i
);

   // Failure count, read by the testbench at the end
   int   fail_cnt = 0;
   logic send_fire;

   assign send_fire = bus_req_i.valid && bus_ready_i && bus_req_i.we &&
                      (bus_req_i.addr == `NA_ADDR_W'(`NA_REG_SEND));

   // Stalled output flit keeps valid, data and last
   a_out_hold: assert property (@(posedge clk) disable iff (rst_i)
      noc_out_i.valid && !noc_out_ready_i |=>
         noc_out_i.valid && $stable(noc_out_i.flit) && $stable(noc_out_i.last))
   else begin
      $error("noc_out flit changed or dropped while stalled");
      fail_cnt++;
   end

   // Header for the accepted command is offered in the next cycle
   a_send_hdr: assert property (@(posedge clk) disable iff (rst_i)
      send_fire |=> noc_out_i.valid &&
         (noc_out_i.flit.hdr.dest == $past(bus_req_i.wdata[`NA_ID_W-1:0])))
   else begin
      $error("header flit not valid one cycle after SEND");
      fail_cnt++;
   end

endmodule

bind na_mpsimple_top na_mpsimple_sva u_sva (
   .clk             (clk),
   .rst_i           (rst_i),
   .bus_req_i       (bus_req_i),
   .bus_ready_i     (bus_ready_o),
   .noc_out_i       (noc_out_o),
   .noc_out_ready_i (noc_out_ready_i)
);

`default_nettype wire

// File: verif/na_checker.sv
`default_nettype none

`include "na_config.svh"

module na_checker #(
   parameter int unsigned TILE_ID = 3
) (
   input  logic                  clk,
   input  logic                  rst_i,
   input  na_pkg::na_bus_req_t   bus_req_i,
   input  logic                  bus_ready_i,
   input  logic [`NA_FLIT_W-1:0] bus_rdata_i,
   input  logic                  bus_rvalid_i,
   input  na_pkg::noc_link_t     noc_in_i,
   input  logic                  noc_in_ready_i,
   input  na_pkg::noc_link_t     noc_out_i,
   input  logic                  noc_out_ready_i,
   output int                    out_left_o,
   output int                    value_errs_o,
   output int                    other_errs_o
);

   import na_pkg::*;

   localparam logic [`NA_ADDR_W-1:0] REG_DATA   = `NA_REG_DATA;
   localparam logic [`NA_ADDR_W-1:0] REG_SEND   = `NA_REG_SEND;
   localparam logic [`NA_ADDR_W-1:0] REG_STATUS = `NA_REG_STATUS;
   localparam logic [`NA_ID_W-1:0]   MY_ID      = TILE_ID[`NA_ID_W-1:0];

   // Expected outbound flits and received words, as {data, last}
   logic [`NA_FLIT_W:0]   out_q[$];
   logic [`NA_FLIT_W:0]   rx_q[$];
   // Words written since the last SEND
   logic [`NA_FLIT_W-1:0] tx_q[$];
   logic [`NA_FLIT_W:0]   out_exp;
   int                    drop_cnt;
   // Inbound packet parse state
   logic                  in_hdr_next;
   logic                  in_local;
   noc_flit_u             in_flit;
   // Read issued last cycle and its predicted data
   logic                  rd_due;
   logic [`NA_FLIT_W-1:0] rd_exp;

   initial begin
      value_errs_o = 0;
      other_errs_o = 0;
      out_left_o   = 0;
   end

   task automatic value_error(input string name, input logic [`NA_FLIT_W-1:0] got,
                              input logic [`NA_FLIT_W-1:0] exp);
      value_errs_o++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic other_error(input string msg);
      other_errs_o++;
      $display("Checker failure at %0t: %s", $time, msg);
   endtask

   // Header then payload in write order, last on the final flit
   task automatic queue_message(input logic [`NA_ID_W-1:0] dest);
      noc_hdr_t  hdr;
      noc_flit_u flit;
      int        len;
      hdr           = '0;
      hdr.dest      = dest;
      hdr.msg_class = `NA_CLASS_MP;
      hdr.src       = MY_ID;
      flit.hdr      = hdr;
      len           = tx_q.size();
      out_q.push_back({flit.data, len == 0});
      for (int i = 0; i < len; i++) begin
         out_q.push_back({tx_q[i], i == len - 1});
      end
      tx_q.delete();
   endtask

   // Register contents before the request's edge
   function automatic logic [`NA_FLIT_W-1:0] predict_read(input logic [`NA_ADDR_W-1:0] addr);
      logic [`NA_FLIT_W-1:0] v;
      int                    pend;
      v    = '0;
      pend = tx_q.size();
      if (addr == REG_DATA) begin
         if (rx_q.size() != 0) begin
            v = rx_q[0][`NA_FLIT_W:1];
         end
      end else if (addr == REG_STATUS) begin
         v[0]     = (rx_q.size() != 0);
         v[1]     = (rx_q.size() != 0) && rx_q[0][0];
         v[15:8]  = pend[7:0];
         v[23:16] = drop_cnt[7:0];
      end
      return v;
   endfunction

   // Everything sampled mid-cycle, where inputs and outputs are settled
   always @(negedge clk) begin
      if (rst_i) begin
         out_q.delete();
         rx_q.delete();
         tx_q.delete();
         drop_cnt    = 0;
         in_hdr_next = 1'b1;
         in_local    = 1'b0;
         rd_due      = 1'b0;
         // Idle outputs during reset
         if (noc_out_i.valid !== 1'b0) value_error("noc_out_o.valid", noc_out_i.valid, 0);
         if (bus_rvalid_i !== 1'b0) value_error("bus_rvalid_o", bus_rvalid_i, 0);
         if (noc_in_ready_i !== 1'b1) value_error("noc_in_ready_o", noc_in_ready_i, 1);
         if (bus_ready_i !== 1'b1) value_error("bus_ready_o", bus_ready_i, 1);
      end else begin
         // Result of last cycle's read
         if (bus_rvalid_i !== rd_due) begin
            if (rd_due) begin
               other_error("read data did not arrive one cycle after the request");
            end else begin
               other_error("read data arrived without a read request");
            end
         end else if (rd_due && bus_rdata_i !== rd_exp) begin
            value_error("bus_rdata_o", bus_rdata_i, rd_exp);
         end
         rd_due = 1'b0;
         // Bus request completing at the coming edge
         if (bus_req_i.valid && bus_ready_i) begin
            if (!bus_req_i.we) begin
               rd_due = 1'b1;
               rd_exp = predict_read(bus_req_i.addr);
               if (bus_req_i.addr == REG_DATA && rx_q.size() != 0) rx_q.delete(0);
            end else if (bus_req_i.addr == REG_DATA) begin
               tx_q.push_back(bus_req_i.wdata);
            end else if (bus_req_i.addr == REG_SEND) begin
               queue_message(bus_req_i.wdata[`NA_ID_W-1:0]);
            end
         end
         // Outbound flit taken at the coming edge
         if (noc_out_i.valid && noc_out_ready_i) begin
            if (out_q.size() == 0) begin
               other_error("flit on noc_out with no message outstanding");
            end else begin
               out_exp = out_q.pop_front();
               if (noc_out_i.flit.data !== out_exp[`NA_FLIT_W:1]) begin
                  value_error("noc_out_o.flit", noc_out_i.flit.data, out_exp[`NA_FLIT_W:1]);
               end
               if (noc_out_i.last !== out_exp[0]) begin
                  value_error("noc_out_o.last", noc_out_i.last, out_exp[0]);
               end
            end
         end
         // Inbound flit accepted at the coming edge
         if (noc_in_i.valid && noc_in_ready_i) begin
            in_flit = noc_in_i.flit;
            if (in_hdr_next) begin
               in_local = (in_flit.hdr.dest == MY_ID);
               if (!in_local) drop_cnt++;
            end else if (in_local) begin
               rx_q.push_back({in_flit.data, noc_in_i.last});
            end
            in_hdr_next = noc_in_i.last;
         end
      end
      out_left_o = out_q.size();
   end

endmodule

`default_nettype wire

// File: verif/tb_na_mpsimple.sv
`default_nettype none

`include "na_config.svh"

module tb_na_mpsimple;

   import na_pkg::*;

   localparam int unsigned TILE_ID    = 3;
   localparam int          CLK_PERIOD = 20;
   localparam int          N_RANDOM   = 250;
   localparam int          N_DIRECTED = 40;
   // About 40 cycles per operation at most
   localparam int          WATCHDOG_TIME = (N_RANDOM + N_DIRECTED) * 40 * CLK_PERIOD;
   // Longer than the rx FIFO, forces back-pressure
   localparam int          STALL_LEN = 12;

   localparam logic [`NA_ADDR_W-1:0] REG_DATA   = `NA_REG_DATA;
   localparam logic [`NA_ADDR_W-1:0] REG_SEND   = `NA_REG_SEND;
   localparam logic [`NA_ADDR_W-1:0] REG_STATUS = `NA_REG_STATUS;

   logic                  clk;
   logic                  rst;
   na_bus_req_t           bus_req;
   logic                  bus_ready;
   logic [`NA_FLIT_W-1:0] bus_rdata;
   logic                  bus_rvalid;
   noc_link_t             noc_in;
   logic                  noc_in_ready;
   noc_link_t             noc_out;
   logic                  noc_out_ready;
   int                    out_left;
   int                    value_errs;
   int                    other_errs;
   integer                seed;
   // Words written since the last SEND, and words sitting in the rx FIFO
   int                    pend_cnt;
   int                    rx_cnt;
   int                    op;
   int                    len;

   na_mpsimple_top #(
      .TILE_ID (TILE_ID)
   ) uut (
      .clk             (clk),
      .rst_i           (rst),
      .bus_req_i       (bus_req),
      .bus_ready_o     (bus_ready),
      .bus_rdata_o     (bus_rdata),
      .bus_rvalid_o    (bus_rvalid),
      .noc_in_i        (noc_in),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_o       (noc_out),
      .noc_out_ready_i (noc_out_ready)
   );

   na_checker #(
      .TILE_ID (TILE_ID)
   ) u_chk (
      .clk             (clk),
      .rst_i           (rst),
      .bus_req_i       (bus_req),
      .bus_ready_i     (bus_ready),
      .bus_rdata_i     (bus_rdata),
      .bus_rvalid_i    (bus_rvalid),
      .noc_in_i        (noc_in),
      .noc_in_ready_i  (noc_in_ready),
      .noc_out_i       (noc_out),
      .noc_out_ready_i (noc_out_ready),
      .out_left_o      (out_left),
      .value_errs_o    (value_errs),
      .other_errs_o    (other_errs)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Random sink back-pressure, mostly ready
   always @(posedge clk) begin
      #2;
      if (rst) begin
         noc_out_ready <= 1'b1;
      end else begin
         noc_out_ready <= ($random(seed) % 4) != 0;
      end
   end

   // One bus request, held until the DUT takes it
   task automatic bus_op(input logic we, input logic [`NA_ADDR_W-1:0] addr,
                         input logic [`NA_FLIT_W-1:0] wdata);
      bus_req.valid = 1'b1;
      bus_req.we    = we;
      bus_req.addr  = addr;
      bus_req.wdata = wdata;
      @(negedge clk);
      while (!bus_ready) @(negedge clk);
      @(posedge clk);
      #2;
      bus_req = '0;
   endtask

   task automatic write_words(input int n);
      for (int i = 0; i < n; i++) begin
         bus_op(1'b1, REG_DATA, $random(seed));
         pend_cnt++;
      end
   endtask

   task automatic read_status();
      bus_op(1'b0, REG_STATUS, '0);
   endtask

   task automatic read_data();
      bus_op(1'b0, REG_DATA, '0);
      if (rx_cnt > 0) rx_cnt--;
   endtask

   // Pending count checked just before each send
   task automatic send_msg(input logic [`NA_ID_W-1:0] dest);
      logic [`NA_FLIT_W-1:0] wdata;
      read_status();
      wdata            = $random(seed);
      wdata[`NA_ID_W-1:0] = dest;
      bus_op(1'b1, REG_SEND, wdata);
      pend_cnt = 0;
   endtask

   task automatic send_flit(input noc_flit_u flit, input logic last);
      noc_in.flit  = flit;
      noc_in.last  = last;
      noc_in.valid = 1'b1;
      @(negedge clk);
      while (!noc_in_ready) @(negedge clk);
      @(posedge clk);
      #2;
      noc_in = '0;
   endtask

   task automatic inject_packet(input logic [`NA_ID_W-1:0] dest, input int n);
      noc_hdr_t              hdr;
      noc_flit_u             flit;
      logic [`NA_FLIT_W-1:0] rnd;
      rnd           = $random(seed);
      hdr           = '0;
      hdr.dest      = dest;
      hdr.msg_class = rnd[2:0];
      hdr.src       = rnd[12:8];
      flit.hdr      = hdr;
      send_flit(flit, n == 0);
      for (int i = 0; i < n; i++) begin
         flit.data = $random(seed);
         send_flit(flit, i == n - 1);
      end
      if (dest == TILE_ID) rx_cnt += n;
      // Idle cycle lets the drop count settle
      @(posedge clk);
      #2;
   endtask

   function automatic logic [`NA_ID_W-1:0] foreign_dest();
      logic [`NA_ID_W-1:0] d;
      d = $unsigned($random(seed)) % 32;
      if (d == TILE_ID) d = d ^ 1;
      return d;
   endfunction

   initial begin
      seed          = 32'h4287;
      clk           = 1'b0;
      rst           = 1'b1;
      bus_req       = '0;
      noc_in        = '0;
      noc_out_ready = 1'b1;
      pend_cnt      = 0;
      rx_cnt        = 0;
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;
      // Status is all zero out of reset
      read_status();

      for (int n = 0; n < N_RANDOM; n++) begin
         op = $unsigned($random(seed)) % 6;
         case (op)
            0: write_words($unsigned($random(seed)) % (`NA_TX_DEPTH + 1 - pend_cnt));
            1: send_msg($unsigned($random(seed)) % 32);
            2: read_status();
            3: repeat (1 + $unsigned($random(seed)) % 3) read_data();
            4: begin
               len = $unsigned($random(seed)) % 5;
               // Room in the rx FIFO so the packet cannot block
               while (rx_cnt + len > `NA_RX_DEPTH) read_data();
               inject_packet(TILE_ID, len);
            end
            default: inject_packet(foreign_dest(), $unsigned($random(seed)) % 7);
         endcase
      end

      // Back-pressure, reads withheld until the input stalls
      while (rx_cnt > 0) read_data();
      fork
         inject_packet(TILE_ID, STALL_LEN);
         begin
            while (noc_in_ready) @(negedge clk);
            @(posedge clk);
            #2;
            read_status();
            repeat (4) read_data();
         end
      join
      rx_cnt = STALL_LEN - 4;
      repeat (rx_cnt + 1) read_data();
      read_status();

      // Flush whatever is left
      if (pend_cnt > 0) send_msg(foreign_dest());
      while (out_left != 0) @(negedge clk);
      repeat (3) @(posedge clk);
      $display("Errors: %0d value, %0d protocol, %0d assertion",
               value_errs, other_errs, uut.u_sva.fail_cnt);
      if (value_errs == 0 && other_errs == 0 && uut.u_sva.fail_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Hang guard
   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired before the test sequence completed");
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: na_mpsimple_top.f
+incdir+hw
hw/na_pkg.sv
hw/msg_fifo.sv
hw/noc_packetizer.sv
hw/noc_depacketizer.sv
hw/na_ctrl.sv
hw/na_mpsimple_top.sv
verif/na_mpsimple_sva.sv
verif/na_checker.sv
verif/tb_na_mpsimple.sv

// File: Bender.yml
package:
  name: na_mpsimple

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/na_pkg.sv
      - hw/msg_fifo.sv
      - hw/noc_packetizer.sv
      - hw/noc_depacketizer.sv
      - hw/na_ctrl.sv
      - hw/na_mpsimple_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/na_mpsimple_sva.sv
      - verif/na_checker.sv
      - verif/tb_na_mpsimple.sv
